//--- axis_async_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module axis_async_fifo #(
    parameter int  DEPTH = 16,
    localparam int AW    = $clog2(DEPTH),
    localparam int PW    = AW + 1
) (
    input  var logic                   rx_clk,
    input  var logic                   tx_clk,
    input  var logic                   arst_n,

    input  var axis_pkg::axis_beat_t   s_beat,
    input  var logic                   s_tvalid,
    output var logic                   s_tready,

    output var axis_pkg::axis_beat_t   m_beat,
    output var logic                   m_tvalid,
    input  var logic                   m_tready,

    output var fifo_pkg::fifo_status_t status,
    output var logic [PW-1:0]          depth
);

    logic                 wr_en;
    logic [AW-1:0]        wr_addr;
    axis_pkg::axis_beat_t wr_data;
    logic                 rd_en;
    logic [AW-1:0]        rd_addr;
    axis_pkg::axis_beat_t rd_data;
    logic [PW-1:0]        commit_gray;
    logic [PW-1:0]        commit_ptr_tx;  // Committed pointer seen on tx side.
    logic [PW-1:0]        rd_gray;
    logic [PW-1:0]        rd_ptr_rx;      // Read pointer seen on rx side.

    axis_fifo_write #(.DEPTH(DEPTH)) u_write (
        .rx_clk      (rx_clk),
        .arst_n      (arst_n),
        .s_beat      (s_beat),
        .s_tvalid    (s_tvalid),
        .s_tready    (s_tready),
        .rd_ptr      (rd_ptr_rx),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .commit_gray (commit_gray),
        .status      (status),
        .depth       (depth)
    );

    gray_ptr_sync #(.DEPTH(DEPTH)) u_commit_sync (
        .clk     (tx_clk),
        .arst_n  (arst_n),
        .gray_in (commit_gray),
        .bin_out (commit_ptr_tx)
    );

    gray_ptr_sync #(.DEPTH(DEPTH)) u_rd_sync (
        .clk     (rx_clk),
        .arst_n  (arst_n),
        .gray_in (rd_gray),
        .bin_out (rd_ptr_rx)
    );

    fifo_ram #(.DEPTH(DEPTH)) u_ram (
        .wr_clk  (rx_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_clk  (tx_clk),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    axis_fifo_read #(.DEPTH(DEPTH)) u_read (
        .tx_clk     (tx_clk),
        .arst_n     (arst_n),
        .commit_ptr (commit_ptr_tx),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_gray    (rd_gray),
        .m_beat     (m_beat),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready)
    );

endmodule

`default_nettype wire

//--- axis_fifo_read.sv
`timescale 1ns/1ns
`default_nettype none

module axis_fifo_read #(
    parameter int  DEPTH = 16,
    localparam int AW    = $clog2(DEPTH),
    localparam int PW    = AW + 1
) (
    input  var logic                 tx_clk,
    input  var logic                 arst_n,

    input  var logic [PW-1:0]        commit_ptr,

    output var logic                 rd_en,
    output var logic [AW-1:0]        rd_addr,
    input  var axis_pkg::axis_beat_t rd_data,

    output var logic [PW-1:0]        rd_gray,

    output var axis_pkg::axis_beat_t m_beat,
    output var logic                 m_tvalid,
    input  var logic                 m_tready
);

    logic [1:0]    rst_sync;
    logic          tx_rst_n;
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] rd_ptr_inc;
    logic          rd_pend;
    logic          out_free;
    logic          load;

    always_ff @(posedge tx_clk or negedge arst_n) begin
        if (!arst_n) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign tx_rst_n = rst_sync[1];

    assign out_free   = !m_tvalid || m_tready;  // Output empty or draining.
    assign rd_en      = tx_rst_n && out_free && (rd_ptr != commit_ptr);
    assign rd_addr    = rd_ptr[AW-1:0];
    assign load       = rd_pend && out_free;
    assign rd_ptr_inc = rd_ptr + PW'(1);

    always_ff @(posedge tx_clk or negedge tx_rst_n) begin
        if (!tx_rst_n) begin
            rd_ptr   <= '0;
            rd_gray  <= '0;
            rd_pend  <= 1'b0;
            m_tvalid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr  <= rd_ptr_inc;
                rd_gray <= rd_ptr_inc ^ (rd_ptr_inc >> 1);
            end
            rd_pend <= rd_en || (rd_pend && !load);  // RAM output holds a word.
            if (load) begin
                m_tvalid <= 1'b1;
            end else if (m_tready) begin
                m_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge tx_clk) begin
        if (load) begin
            m_beat <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- axis_fifo_write.sv
`timescale 1ns/1ns
`default_nettype none

module axis_fifo_write #(
    parameter int  DEPTH = 16,
    localparam int AW    = $clog2(DEPTH),
    localparam int PW    = AW + 1
) (
    input  var logic                   rx_clk,
    input  var logic                   arst_n,

    input  var axis_pkg::axis_beat_t   s_beat,
    input  var logic                   s_tvalid,
    output var logic                   s_tready,

    input  var logic [PW-1:0]          rd_ptr,

    output var logic                   wr_en,
    output var logic [AW-1:0]          wr_addr,
    output var axis_pkg::axis_beat_t   wr_data,

    output var logic [PW-1:0]          commit_gray,
    output var fifo_pkg::fifo_status_t status,
    output var logic [PW-1:0]          depth
);

    logic [1:0]             rst_sync;
    logic                   rx_rst_n;
    fifo_pkg::wr_state_t    state;
    logic [PW-1:0]          wr_ptr;
    logic [PW-1:0]          wr_ptr_inc;
    logic [PW-1:0]          start_ptr;
    logic [PW-1:0]          commit_ptr;
    logic [PW-1:0]          frame_len;
    logic [PW-1:0]          used;
    logic                   full;
    logic                   oversize;
    logic                   accept;
    logic                   bad_last;
    fifo_pkg::fifo_status_t event_q;

    always_ff @(posedge rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign rx_rst_n = rst_sync[1];

    assign wr_ptr_inc = wr_ptr + PW'(1);
    assign frame_len  = wr_ptr - start_ptr;
    assign used       = wr_ptr - rd_ptr;     // Pessimistic, rd_ptr lags.
    assign full       = used[AW];            // Never exceeds DEPTH.
    assign oversize   = frame_len[AW];       // Frame already holds DEPTH beats.

    assign s_tready = rx_rst_n && (state == fifo_pkg::WR_DROP || !full || oversize);
    assign accept   = s_tvalid && s_tready;
    assign bad_last = s_beat.tlast && s_beat.tuser[fifo_pkg::BAD_FRAME_BIT];

    assign wr_en   = accept && state != fifo_pkg::WR_DROP && !oversize;
    assign wr_addr = wr_ptr[AW-1:0];
    assign wr_data = s_beat;

    always_ff @(posedge rx_clk or negedge rx_rst_n) begin
        if (!rx_rst_n) begin
            state       <= fifo_pkg::WR_IDLE;
            wr_ptr      <= '0;
            start_ptr   <= '0;
            commit_ptr  <= '0;
            commit_gray <= '0;
            event_q     <= '0;
            status      <= '0;
            depth       <= '0;
        end else begin
            event_q     <= '0;
            status      <= event_q;                     // Strobes one edge after the event.
            commit_ptr  <= start_ptr;
            commit_gray <= start_ptr ^ (start_ptr >> 1);
            depth       <= commit_ptr - rd_ptr;
            if (accept) begin
                case (state)
                    fifo_pkg::WR_DROP: begin
                        if (s_beat.tlast) begin
                            state <= fifo_pkg::WR_IDLE;
                        end
                    end
                    default: begin
                        if (oversize) begin
                            wr_ptr           <= start_ptr;  // Rewind.
                            event_q.overflow <= 1'b1;
                            state            <= s_beat.tlast ? fifo_pkg::WR_IDLE
                                                             : fifo_pkg::WR_DROP;
                        end else if (bad_last) begin
                            wr_ptr            <= start_ptr;
                            event_q.bad_frame <= 1'b1;
                            state             <= fifo_pkg::WR_IDLE;
                        end else if (s_beat.tlast) begin
                            wr_ptr             <= wr_ptr_inc;
                            start_ptr          <= wr_ptr_inc;  // Commit point.
                            event_q.good_frame <= 1'b1;
                            state              <= fifo_pkg::WR_IDLE;
                        end else begin
                            wr_ptr <= wr_ptr_inc;
                            state  <= fifo_pkg::WR_FRAME;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- axis_pkg.sv
package axis_pkg;

    localparam int DATA_W = 8;
    localparam int KEEP_W = 1;
    localparam int ID_W   = 4;
    localparam int DEST_W = 4;
    localparam int USER_W = 2;

    // One stream beat, also the RAM word.
    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [KEEP_W-1:0] tkeep;
        logic              tlast;
        logic [ID_W-1:0]   tid;
        logic [DEST_W-1:0] tdest;
        logic [USER_W-1:0] tuser;
    } axis_beat_t;

endpackage

//--- fifo_pkg.sv
package fifo_pkg;

    localparam int BAD_FRAME_BIT = 0;  // tuser bit that marks a bad frame.

    typedef enum logic [1:0] {
        WR_IDLE,   // Between frames.
        WR_FRAME,  // Frame in progress.
        WR_DROP    // Oversize frame, discard until tlast.
    } wr_state_t;

    // Single-cycle strobes, write clock domain.
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } fifo_status_t;

endpackage

//--- fifo_ram.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_ram #(
    parameter int  DEPTH = 16,
    localparam int AW    = $clog2(DEPTH)
) (
    input  var logic                 wr_clk,
    input  var logic                 wr_en,
    input  var logic [AW-1:0]        wr_addr,
    input  var axis_pkg::axis_beat_t wr_data,

    input  var logic                 rd_clk,
    input  var logic                 rd_en,
    input  var logic [AW-1:0]        rd_addr,
    output var axis_pkg::axis_beat_t rd_data
);

    axis_pkg::axis_beat_t mem [DEPTH];

    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];  // Registered read.
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
axis_pkg.sv
fifo_pkg.sv
fifo_ram.sv
gray_ptr_sync.sv
axis_fifo_write.sv
axis_fifo_read.sv
axis_async_fifo.sv
tb_axis_async_fifo.sv

//--- gray_ptr_sync.sv
`timescale 1ns/1ns
`default_nettype none

module gray_ptr_sync #(
    parameter int  DEPTH = 16,
    localparam int PW    = $clog2(DEPTH) + 1
) (
    input  var logic          clk,
    input  var logic          arst_n,
    input  var logic [PW-1:0] gray_in,
    output var logic [PW-1:0] bin_out
);

    logic [PW-1:0] sync_q1;
    logic [PW-1:0] sync_q2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= gray_in;  // First stage may go metastable.
            sync_q2 <= sync_q1;
        end
    end

    // Each binary bit is the XOR of all Gray bits at and above it.
    always_comb begin
        for (int i = 0; i < PW; i++) begin
            bin_out[i] = ^(sync_q2 >> i);
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_axis_async_fifo -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

//--- tb_axis_async_fifo.sv
`timescale 1ns/1ns

module tb_axis_async_fifo;

    localparam int DEPTH     = 16;
    localparam int PW        = $clog2(DEPTH) + 1;
    localparam int TX_PERIOD = 14;
    localparam int NUM_ROWS  = 11;

    localparam logic [1:0] OUT_PASS = 2'd0;
    localparam logic [1:0] OUT_BAD  = 2'd1;
    localparam logic [1:0] OUT_OVF  = 2'd2;

    typedef struct packed {
        int                          len;
        logic                        bad;
        logic [axis_pkg::ID_W-1:0]   tid;
        logic [axis_pkg::DEST_W-1:0] tdest;
        logic [axis_pkg::DATA_W-1:0] base;
        logic [1:0]                  outcome;
        logic                        hold;     // Stall the sink until the FIFO fills.
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{1,  1'b0, 4'h1, 4'h2, 8'h00, OUT_PASS, 1'b0},
        '{12, 1'b0, 4'h2, 4'h3, 8'h10, OUT_PASS, 1'b0},
        '{5,  1'b1, 4'h3, 4'h4, 8'h20, OUT_BAD,  1'b0},
        '{3,  1'b0, 4'h4, 4'h5, 8'h30, OUT_PASS, 1'b0},
        '{20, 1'b0, 4'h5, 4'h6, 8'h40, OUT_OVF,  1'b0},
        '{4,  1'b0, 4'h6, 4'h7, 8'h60, OUT_PASS, 1'b0},
        '{8,  1'b0, 4'h7, 4'h8, 8'h70, OUT_PASS, 1'b1},
        '{8,  1'b0, 4'h8, 4'h9, 8'h80, OUT_PASS, 1'b0},
        '{6,  1'b0, 4'h9, 4'ha, 8'h90, OUT_PASS, 1'b0},
        '{2,  1'b1, 4'ha, 4'hb, 8'ha0, OUT_BAD,  1'b0},
        '{7,  1'b0, 4'hb, 4'hc, 8'hb0, OUT_PASS, 1'b0}
    };

    logic                   rx_clk;
    logic                   tx_clk;
    logic                   arst_n;
    axis_pkg::axis_beat_t   s_beat;
    logic                   s_tvalid;
    logic                   s_tready;
    axis_pkg::axis_beat_t   m_beat;
    logic                   m_tvalid;
    logic                   m_tready;
    fifo_pkg::fifo_status_t status;
    logic [PW-1:0]          depth;

    integer                 seed = 32'h56a7;
    int                     errors;
    int                     beats_checked;
    int                     ovf_cnt;
    int                     bad_cnt;
    int                     good_cnt;
    logic                   hold_sink;
    logic                   stall_seen;
    axis_pkg::axis_beat_t   expected [$];

    axis_async_fifo #(.DEPTH(DEPTH)) DUT (
        .rx_clk   (rx_clk),
        .tx_clk   (tx_clk),
        .arst_n   (arst_n),
        .s_beat   (s_beat),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .m_beat   (m_beat),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .status   (status),
        .depth    (depth)
    );

    initial begin
        rx_clk = 1'b0;
        forever #5 rx_clk = ~rx_clk;
    end

    initial begin
        tx_clk = 1'b0;
        forever #(TX_PERIOD / 2) tx_clk = ~tx_clk;
    end

    task automatic check_beat(input axis_pkg::axis_beat_t got, input axis_pkg::axis_beat_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: m_beat got %h expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input fifo_pkg::fifo_status_t got,
                                input fifo_pkg::fifo_status_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: status got %b expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_depth(input logic [PW-1:0] got, input logic [PW-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: depth got %0d expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic axis_pkg::axis_beat_t make_beat(input row_t row, input int i);
        axis_pkg::axis_beat_t b;
        b       = '0;
        b.tdata = row.base + i[axis_pkg::DATA_W-1:0];
        b.tkeep = 1'b1;
        b.tlast = (i == row.len - 1);
        b.tid   = row.tid;
        b.tdest = row.tdest;
        b.tuser[fifo_pkg::BAD_FRAME_BIT] = row.bad && b.tlast;
        return b;
    endfunction

    function automatic string outcome_name(input logic [1:0] outcome);
        if (outcome == OUT_BAD) begin
            return "bad";
        end else if (outcome == OUT_OVF) begin
            return "overflow";
        end
        return "pass";
    endfunction

    function automatic int total_len();
        int sum;
        sum = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            sum += ROWS[r].len;
        end
        return sum;
    endfunction

    // Beat is taken at the rising edge after the falling edge where s_tready is seen high.
    task automatic drive_beat(input axis_pkg::axis_beat_t b, input logic in_tail);
        @(negedge rx_clk);
        s_beat   = b;
        s_tvalid = 1'b1;
        if (in_tail) begin
            check_flag("s_tready", s_tready, 1'b1);
        end
        while (!s_tready) begin
            if (hold_sink) begin
                stall_seen = 1'b1;
                hold_sink  = 1'b0;  // FIFO is full so the sink may drain.
            end
            @(negedge rx_clk);
        end
    endtask

    task automatic run_row(input int idx);
        row_t                   row;
        axis_pkg::axis_beat_t   beat;
        fifo_pkg::fifo_status_t got_st;
        fifo_pkg::fifo_status_t exp_st;
        int                     ovf0;
        int                     bad0;
        int                     good0;
        int                     err0;
        int                     wait_cnt;
        row   = ROWS[idx];
        ovf0  = ovf_cnt;
        bad0  = bad_cnt;
        good0 = good_cnt;
        err0  = errors;
        if (row.hold) begin
            hold_sink = 1'b1;
        end
        for (int i = 0; i < row.len; i++) begin
            beat = make_beat(row, i);
            if (row.outcome == OUT_PASS) begin
                expected.push_back(beat);
            end
            drive_beat(beat, (row.outcome == OUT_OVF) && (i >= DEPTH));
        end
        @(negedge rx_clk);
        s_tvalid = 1'b0;
        s_beat   = '0;
        wait_cnt = 0;
        while ((ovf_cnt + bad_cnt + good_cnt) == (ovf0 + bad0 + good0) && wait_cnt < 10) begin
            @(negedge rx_clk);
            wait_cnt++;
        end
        repeat (3) @(negedge rx_clk);  // Room for a stray second strobe.
        got_st.overflow   = (ovf_cnt - ovf0) == 1;
        got_st.bad_frame  = (bad_cnt - bad0) == 1;
        got_st.good_frame = (good_cnt - good0) == 1;
        exp_st.overflow   = row.outcome == OUT_OVF;
        exp_st.bad_frame  = row.outcome == OUT_BAD;
        exp_st.good_frame = row.outcome == OUT_PASS;
        check_status(got_st, exp_st);
        $display("Row %0d: len %0d %s, %s", idx, row.len, outcome_name(row.outcome),
                 (errors == err0) ? "ok" : "errors");
    endtask

    // Status strobes are stable between rising edges.
    always @(negedge rx_clk) begin
        if (status.overflow) begin
            ovf_cnt++;
        end
        if (status.bad_frame) begin
            bad_cnt++;
        end
        if (status.good_frame) begin
            good_cnt++;
        end
    end

    // Sink and scoreboard. A beat moves at the next rising edge when valid and ready.
    initial begin : sink
        logic [31:0]          rnd;
        logic                 ready_next;
        axis_pkg::axis_beat_t exp_beat;
        forever begin
            @(negedge tx_clk);
            rnd        = $random(seed);
            ready_next = !hold_sink && (rnd[1:0] != 2'b00);
            m_tready   = ready_next;
            if (m_tvalid && ready_next) begin
                if (expected.size() == 0) begin
                    $display("Unexpected output beat at %0t ns with nothing expected", $time);
                    errors++;
                end else begin
                    exp_beat = expected.pop_front();
                    check_beat(m_beat, exp_beat);
                    beats_checked++;
                end
            end
        end
    end

    initial begin : watchdog
        int limit_ns;
        limit_ns = total_len() * 4 * TX_PERIOD + 2000;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        int wait_cnt;
        arst_n        = 1'b0;
        s_tvalid      = 1'b0;
        s_beat        = '0;
        m_tready      = 1'b0;
        hold_sink     = 1'b0;
        stall_seen    = 1'b0;
        errors        = 0;
        beats_checked = 0;
        ovf_cnt       = 0;
        bad_cnt       = 0;
        good_cnt      = 0;
        repeat (4) @(negedge rx_clk);
        arst_n = 1'b1;

        wait_cnt = 0;
        while (!s_tready && wait_cnt < 20) begin
            @(negedge rx_clk);
            wait_cnt++;
        end
        if (!s_tready) begin
            $display("s_tready never rose after reset");
            errors++;
        end
        check_flag("m_tvalid", m_tvalid, 1'b0);
        check_status(status, '0);
        check_depth(depth, '0);
        $display("Reset check: %s", (errors == 0) ? "ok" : "errors");

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        if (!stall_seen) begin
            $display("s_tready never went low while the sink was stalled");
            errors++;
        end
        hold_sink = 1'b0;

        wait_cnt = 0;
        while ((expected.size() != 0 || m_tvalid) && wait_cnt < 1000) begin
            @(negedge rx_clk);
            wait_cnt++;
        end
        if (expected.size() != 0) begin
            $display("Output did not drain, %0d beats never arrived", expected.size());
            errors++;
        end
        wait_cnt = 0;
        while (depth != '0 && wait_cnt < 20) begin
            @(negedge rx_clk);
            wait_cnt++;
        end
        check_depth(depth, '0);
        $display("Drain check: %0d beats left, depth %0d", expected.size(), depth);

        $display("Rows %0d, beats checked %0d, errors %0d", NUM_ROWS, beats_checked, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
